// ==== Makefile ====
TOP = tbMips

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o V$(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== mipsAlu.sv ====
`timescale 1ns/1ps

module mipsAlu (
   input  mipsPkg::aluOpT op,
   input  mipsPkg::wordT  a,
   input  mipsPkg::wordT  b,
   output mipsPkg::wordT  result,
   output logic           zero
);
   import mipsPkg::*;

   logic        subtract;
   wordT        bOperand;
   logic [32:0] sum;
   logic        overflow;
   logic        lessSigned;
   logic        lessUnsigned;

   // one adder, subtraction as a + ~b + 1
   assign subtract = (op != aluAdd);
   assign bOperand = subtract ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, bOperand} + {32'd0, subtract};

   // same-sign operands giving a result of the other sign
   assign overflow   = (a[31] == bOperand[31]) && (sum[31] != a[31]);
   assign lessSigned = sum[31] ^ overflow;

   // no carry out of the subtraction means a borrow
   assign lessUnsigned = ~sum[32];

   always_comb begin
      case (op)
         aluAdd,
         aluSub:  result = sum[31:0];
         aluSlt:  result = {31'd0, lessSigned};
         aluSltu: result = {31'd0, lessUnsigned};
         aluAnd:  result = a & b;
         aluOr:   result = a | b;
         aluNor:  result = ~(a | b);
         aluXor:  result = a ^ b;
         // immediate sits in b, moved to the upper half
         aluLui:  result = {b[15:0], 16'h0000};
         default: result = sum[31:0];
      endcase
   end

   assign zero = (result == 32'd0);

endmodule

// ==== mipsChk.sv ====
`timescale 1ns/1ps

module mipsChk (
   input logic clk,
   input logic reset,
   input logic memRead,
   input logic memWrite
);

   // read and write levels are exclusive
   assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
      else $error("memRead and memWrite high together");

   // one write cycle per store
   assert property (@(posedge clk) disable iff (reset) memWrite |=> !memWrite)
      else $error("memWrite high for two cycles in a row");

   // levels cleared once reset has been seen at an edge
   assert property (@(posedge clk) (reset && $past(reset)) |-> (!memRead && !memWrite))
      else $error("memory strobe high during reset");

endmodule

// ==== mipsControl.sv ====
`timescale 1ns/1ps

module mipsControl (
   input  logic              clk,
   input  logic              reset,
   input  mipsPkg::wordT     instr,
   input  logic              aluZero,
   output logic              pcWrite,
   output mipsPkg::pcSrcT    pcSrc,
   output logic              marWrite,
   output mipsPkg::addrSrcT  addrSrc,
   output logic              irWrite,
   output logic              mdrWrite,
   output logic              abWrite,
   output logic              rfWrite,
   output mipsPkg::regDstT   regDst,
   output mipsPkg::wbSrcT    wbSrc,
   output logic              aluSelA,
   output mipsPkg::aluBSrcT  aluBSel,
   output mipsPkg::aluOpT    aluOp,
   output logic              sgnExt,
   output logic              setRead,
   output logic              clrRead,
   output logic              setWrite,
   output logic              clrWrite
);
   import mipsPkg::*;

   ctrlStateT state;
   ctrlStateT nextState;
   opcodeT    opcode;
   functT     funct;
   logic      prepFetch;
   logic      branchTaken;

   assign opcode = instr[31:26];
   assign funct  = instr[5:0];

   // beq on equal, bne on not equal
   assign branchTaken = (opcode == opBeq) ? aluZero : ~aluZero;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= stReset;
      end else begin
         state <= nextState;
      end
   end

   // ============================================================
   // next state and strobes
   // ============================================================
   always_comb begin
      nextState = stReset;
      prepFetch = 1'b0;
      pcWrite   = 1'b0;
      pcSrc     = pcAlu;
      marWrite  = 1'b0;
      addrSrc   = addrPc;
      irWrite   = 1'b0;
      mdrWrite  = 1'b0;
      abWrite   = 1'b0;
      rfWrite   = 1'b0;
      regDst    = dstRt;
      wbSrc     = wbAlu;
      aluSelA   = 1'b0;
      aluBSel   = aluBRegB;
      aluOp     = aluAdd;
      sgnExt    = 1'b0;
      setRead   = 1'b0;
      clrRead   = 1'b0;
      setWrite  = 1'b0;
      clrWrite  = 1'b0;

      case (state)
         stReset: prepFetch = 1'b1;
         stFetch1: nextState = stFetch2;
         stFetch2: nextState = stFetch3;
         stFetch3: begin
            // latch instruction, PC + 4
            irWrite   = 1'b1;
            clrRead   = 1'b1;
            pcWrite   = 1'b1;
            aluBSel   = aluBFour;
            nextState = stDecode;
         end
         stDecode: begin
            abWrite = 1'b1;
            case (opcode)
               opRtype: begin
                  case (funct)
                     fnAdd, fnAddu, fnSub, fnSubu, fnAnd,
                     fnOr, fnXor, fnNor, fnSlt, fnSltu: nextState = stAluR;
                     fnJr: nextState = stJr;
                     default: prepFetch = 1'b1;
                  endcase
               end
               opAddi, opAddiu, opSlti, opSltiu,
               opAndi, opOri, opXori, opLui: nextState = stAluI;
               opLw: nextState = stLw1;
               opSw: nextState = stSw1;
               opBeq, opBne: nextState = stBra1;
               opJ: nextState = stJ;
               opJal: nextState = stJal;
               // unknown opcode acts as a no-op
               default: prepFetch = 1'b1;
            endcase
         end
         stAluR: begin
            aluSelA = 1'b1;
            regDst  = dstRd;
            rfWrite = 1'b1;
            case (funct)
               fnSub, fnSubu: aluOp = aluSub;
               fnAnd:   aluOp = aluAnd;
               fnOr:    aluOp = aluOr;
               fnXor:   aluOp = aluXor;
               fnNor:   aluOp = aluNor;
               fnSlt:   aluOp = aluSlt;
               fnSltu:  aluOp = aluSltu;
               default: aluOp = aluAdd;
            endcase
            prepFetch = 1'b1;
         end
         stAluI: begin
            aluSelA = 1'b1;
            aluBSel = aluBImm;
            rfWrite = 1'b1;
            case (opcode)
               opSlti: begin
                  sgnExt = 1'b1;
                  aluOp  = aluSlt;
               end
               // unsigned compare against the sign-extended immediate
               opSltiu: begin
                  sgnExt = 1'b1;
                  aluOp  = aluSltu;
               end
               opAndi:  aluOp = aluAnd;
               opOri:   aluOp = aluOr;
               opXori:  aluOp = aluXor;
               opLui:   aluOp = aluLui;
               default: sgnExt = 1'b1;
            endcase
            prepFetch = 1'b1;
         end
         stLw1, stSw1: begin
            // effective address into MAR
            aluSelA   = 1'b1;
            aluBSel   = aluBImm;
            sgnExt    = 1'b1;
            addrSrc   = addrAlu;
            marWrite  = 1'b1;
            setRead   = (state == stLw1);
            setWrite  = (state == stSw1);
            nextState = (state == stLw1) ? stLw2 : stSw2;
         end
         stLw2: nextState = stLw3;
         stLw3: nextState = stLw4;
         stLw4: begin
            mdrWrite  = 1'b1;
            clrRead   = 1'b1;
            nextState = stLw5;
         end
         stLw5: begin
            wbSrc     = wbMdr;
            rfWrite   = 1'b1;
            prepFetch = 1'b1;
         end
         stSw2: begin
            clrWrite  = 1'b1;
            nextState = stSw3;
         end
         stSw3: prepFetch = 1'b1;
         stBra1: begin
            aluSelA = 1'b1;
            aluOp   = aluSub;
            if (branchTaken) begin
               nextState = stBra2;
            end else begin
               prepFetch = 1'b1;
            end
         end
         stBra2: begin
            // PC + 4 plus the scaled offset
            aluBSel   = aluBImmSh2;
            sgnExt    = 1'b1;
            pcWrite   = 1'b1;
            addrSrc   = addrAlu;
            marWrite  = 1'b1;
            setRead   = 1'b1;
            nextState = stFetch1;
         end
         stJ, stJal: begin
            pcSrc     = pcJump;
            pcWrite   = 1'b1;
            addrSrc   = addrJump;
            marWrite  = 1'b1;
            setRead   = 1'b1;
            regDst    = dstRa;
            wbSrc     = wbPc;
            rfWrite   = (state == stJal);
            nextState = stFetch1;
         end
         stJr: begin
            pcSrc     = pcRegA;
            pcWrite   = 1'b1;
            addrSrc   = addrRegA;
            marWrite  = 1'b1;
            setRead   = 1'b1;
            nextState = stFetch1;
         end
         default: prepFetch = 1'b1;
      endcase

      // shared step: MAR from PC and start the fetch read
      if (prepFetch) begin
         addrSrc   = addrPc;
         marWrite  = 1'b1;
         setRead   = 1'b1;
         nextState = stFetch1;
      end
   end

endmodule

// ==== mipsDatapath.sv ====
`timescale 1ns/1ps

module mipsDatapath #(
   parameter mipsPkg::wordT resetAddr = 32'd0
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              pcWrite,
   input  mipsPkg::pcSrcT    pcSrc,
   input  logic              marWrite,
   input  mipsPkg::addrSrcT  addrSrc,
   input  logic              irWrite,
   input  logic              mdrWrite,
   input  logic              abWrite,
   input  logic              rfWrite,
   input  mipsPkg::regDstT   regDst,
   input  mipsPkg::wbSrcT    wbSrc,
   input  logic              aluSelA,
   input  mipsPkg::aluBSrcT  aluBSel,
   input  mipsPkg::aluOpT    aluOp,
   input  logic              sgnExt,
   input  logic              setRead,
   input  logic              clrRead,
   input  logic              setWrite,
   input  logic              clrWrite,
   input  mipsPkg::wordT     memReadData,
   output mipsPkg::wordT     instr,
   output logic              aluZero,
   output mipsPkg::wordT     memAddr,
   output mipsPkg::wordT     memWriteData,
   output logic              memRead,
   output logic              memWrite
);
   import mipsPkg::*;

   wordT    pc, ir, mdr, mar, regA, regB;
   logic    readLevel, writeLevel;
   wordT    rfData1, rfData2;
   wordT    extImm, jumpTarget;
   wordT    aluA, aluB, aluResult;
   wordT    writeBack;
   regAddrT writeReg;

   // ============================================================
   // architectural and staging registers
   // ============================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= resetAddr;
      end else if (pcWrite) begin
         case (pcSrc)
            pcJump:  pc <= jumpTarget;
            pcRegA:  pc <= regA;
            default: pc <= aluResult;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (marWrite) begin
         case (addrSrc)
            addrPc:   mar <= pc;
            addrAlu:  mar <= aluResult;
            addrJump: mar <= jumpTarget;
            default:  mar <= regA;
         endcase
      end
      if (irWrite) begin
         ir <= memReadData;
      end
      if (mdrWrite) begin
         mdr <= memReadData;
      end
      if (abWrite) begin
         regA <= rfData1;
         regB <= rfData2;
      end
   end

   // memory strobe levels, clear wins over set
   always_ff @(posedge clk) begin
      if (reset || clrRead) begin
         readLevel <= 1'b0;
      end else if (setRead) begin
         readLevel <= 1'b1;
      end
      if (reset || clrWrite) begin
         writeLevel <= 1'b0;
      end else if (setWrite) begin
         writeLevel <= 1'b1;
      end
   end

   // ============================================================
   // operand and write-back muxes
   // ============================================================
   assign extImm     = sgnExt ? {{16{ir[15]}}, ir[15:0]} : {16'h0000, ir[15:0]};
   assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};
   assign aluA       = aluSelA ? regA : pc;

   always_comb begin
      case (aluBSel)
         aluBRegB:   aluB = regB;
         aluBFour:   aluB = 32'd4;
         aluBImm:    aluB = extImm;
         default:    aluB = {extImm[29:0], 2'b00};
      endcase
   end

   always_comb begin
      case (regDst)
         dstRd:   writeReg = ir[15:11];
         dstRa:   writeReg = 5'd31;
         default: writeReg = ir[20:16];
      endcase
   end

   always_comb begin
      case (wbSrc)
         wbMdr:   writeBack = mdr;
         wbPc:    writeBack = pc;
         default: writeBack = aluResult;
      endcase
   end

   mipsAlu aluInst (
      .op     (aluOp),
      .a      (aluA),
      .b      (aluB),
      .result (aluResult),
      .zero   (aluZero)
   );

   regFile rfInst (
      .clk       (clk),
      .rfWrite   (rfWrite),
      .readAddr1 (ir[25:21]),
      .readAddr2 (ir[20:16]),
      .writeAddr (writeReg),
      .writeData (writeBack),
      .readData1 (rfData1),
      .readData2 (rfData2)
   );

   assign instr        = ir;
   assign memAddr      = mar;
   assign memWriteData = regB;
   assign memRead      = readLevel;
   assign memWrite     = writeLevel;

endmodule

// ==== mipsPkg.sv ====
package mipsPkg;

   // ============================================================
   // word and field types
   // ============================================================
   typedef logic [31:0] wordT;
   typedef logic [4:0]  regAddrT;
   typedef logic [5:0]  opcodeT;
   typedef logic [5:0]  functT;

   // ============================================================
   // datapath select codes
   // ============================================================
   typedef enum logic [3:0] {
      aluAdd, aluSub, aluSlt, aluSltu, aluAnd, aluOr, aluNor, aluXor, aluLui
   } aluOpT;

   typedef enum logic [1:0] {pcAlu, pcJump, pcRegA} pcSrcT;
   typedef enum logic [1:0] {addrPc, addrAlu, addrJump, addrRegA} addrSrcT;
   typedef enum logic [1:0] {aluBRegB, aluBFour, aluBImm, aluBImmSh2} aluBSrcT;
   typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
   typedef enum logic [1:0] {wbAlu, wbMdr, wbPc} wbSrcT;

   // controller states
   typedef enum logic [4:0] {
      stReset, stFetch1, stFetch2, stFetch3, stDecode,
      stAluR, stAluI,
      stLw1, stLw2, stLw3, stLw4, stLw5,
      stSw1, stSw2, stSw3,
      stBra1, stBra2,
      stJ, stJal, stJr
   } ctrlStateT;

   // ============================================================
   // opcode and funct values
   // ============================================================
   localparam opcodeT opRtype = 6'h00;
   localparam opcodeT opJ     = 6'h02;
   localparam opcodeT opJal   = 6'h03;
   localparam opcodeT opBeq   = 6'h04;
   localparam opcodeT opBne   = 6'h05;
   localparam opcodeT opAddi  = 6'h08;
   localparam opcodeT opAddiu = 6'h09;
   localparam opcodeT opSlti  = 6'h0a;
   localparam opcodeT opSltiu = 6'h0b;
   localparam opcodeT opAndi  = 6'h0c;
   localparam opcodeT opOri   = 6'h0d;
   localparam opcodeT opXori  = 6'h0e;
   localparam opcodeT opLui   = 6'h0f;
   localparam opcodeT opLw    = 6'h23;
   localparam opcodeT opSw    = 6'h2b;

   localparam functT fnJr   = 6'h08;
   localparam functT fnAdd  = 6'h20;
   localparam functT fnAddu = 6'h21;
   localparam functT fnSub  = 6'h22;
   localparam functT fnSubu = 6'h23;
   localparam functT fnAnd  = 6'h24;
   localparam functT fnOr   = 6'h25;
   localparam functT fnXor  = 6'h26;
   localparam functT fnNor  = 6'h27;
   localparam functT fnSlt  = 6'h2a;
   localparam functT fnSltu = 6'h2b;

endpackage

// ==== multiCycleMips.sv ====
`timescale 1ns/1ps

module multiCycleMips #(
   parameter mipsPkg::wordT resetAddr = 32'd0
) (
   input  logic          clk,
   input  logic          reset,
   output mipsPkg::wordT memAddr,
   input  mipsPkg::wordT memReadData,
   output mipsPkg::wordT memWriteData,
   output logic          memRead,
   output logic          memWrite
);
   import mipsPkg::*;

   // controller to datapath
   logic    pcWrite, marWrite, irWrite, mdrWrite, abWrite, rfWrite;
   logic    aluSelA, sgnExt;
   logic    setRead, clrRead, setWrite, clrWrite;
   pcSrcT   pcSrc;
   addrSrcT addrSrc;
   regDstT  regDst;
   wbSrcT   wbSrc;
   aluBSrcT aluBSel;
   aluOpT   aluOp;

   // datapath to controller
   wordT instr;
   logic aluZero;

   mipsControl controlInst (
      .clk      (clk),      .reset    (reset),
      .instr    (instr),    .aluZero  (aluZero),
      .pcWrite  (pcWrite),  .pcSrc    (pcSrc),
      .marWrite (marWrite), .addrSrc  (addrSrc),
      .irWrite  (irWrite),  .mdrWrite (mdrWrite),
      .abWrite  (abWrite),  .rfWrite  (rfWrite),
      .regDst   (regDst),   .wbSrc    (wbSrc),
      .aluSelA  (aluSelA),  .aluBSel  (aluBSel),
      .aluOp    (aluOp),    .sgnExt   (sgnExt),
      .setRead  (setRead),  .clrRead  (clrRead),
      .setWrite (setWrite), .clrWrite (clrWrite)
   );

   mipsDatapath #(.resetAddr(resetAddr)) datapathInst (
      .clk          (clk),          .reset    (reset),
      .pcWrite      (pcWrite),      .pcSrc    (pcSrc),
      .marWrite     (marWrite),     .addrSrc  (addrSrc),
      .irWrite      (irWrite),      .mdrWrite (mdrWrite),
      .abWrite      (abWrite),      .rfWrite  (rfWrite),
      .regDst       (regDst),       .wbSrc    (wbSrc),
      .aluSelA      (aluSelA),      .aluBSel  (aluBSel),
      .aluOp        (aluOp),        .sgnExt   (sgnExt),
      .setRead      (setRead),      .clrRead  (clrRead),
      .setWrite     (setWrite),     .clrWrite (clrWrite),
      .memReadData  (memReadData),  .instr    (instr),
      .aluZero      (aluZero),      .memAddr  (memAddr),
      .memWriteData (memWriteData), .memRead  (memRead),
      .memWrite     (memWrite)
   );

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
   input  logic             clk,
   input  logic             rfWrite,
   input  mipsPkg::regAddrT readAddr1,
   input  mipsPkg::regAddrT readAddr2,
   input  mipsPkg::regAddrT writeAddr,
   input  mipsPkg::wordT    writeData,
   output mipsPkg::wordT    readData1,
   output mipsPkg::wordT    readData2
);
   import mipsPkg::*;

   wordT regs [32];

   // register 0 is never written
   always_ff @(posedge clk) begin
      if (rfWrite && (writeAddr != 5'd0)) begin
         regs[writeAddr] <= writeData;
      end
   end

   // asynchronous reads, r0 always reads as zero
   assign readData1 = (readAddr1 == 5'd0) ? 32'd0 : regs[readAddr1];
   assign readData2 = (readAddr2 == 5'd0) ? 32'd0 : regs[readAddr2];

endmodule

// ==== tbIsaModel.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

   // ============================================================
   // instruction-level reference model
   // ============================================================
   wordT modelReg [32];
   wordT modelMem [memWords];
   wordT expAddr [$];
   wordT expData [$];
   wordT expRead [$];

   task automatic runModel();
      wordT pcM;
      wordT ins;
      wordT rsV;
      wordT rtV;
      wordT sImm;
      wordT zImm;
      wordT res;
      int   steps;
      for (int i = 0; i < 32; i++) modelReg[i] = 32'd0;
      for (int i = 0; i < memWords; i++) modelMem[i] = mem[i];
      pcM = 32'd0;
      steps = 0;
      while (pcM != endAddr) begin
         steps++;
         if (steps > 100000) reportFailure("reference model did not reach the end loop");
         ins = modelMem[pcM[13:2]];
         // instruction fetch read
         expRead.push_back(pcM);
         pcM = pcM + 32'd4;
         rsV = modelReg[ins[25:21]];
         rtV = modelReg[ins[20:16]];
         sImm = {{16{ins[15]}}, ins[15:0]};
         zImm = {16'd0, ins[15:0]};
         case (ins[31:26])
            opRtype: begin
               case (ins[5:0])
                  fnAdd, fnAddu: modelReg[ins[15:11]] = rsV + rtV;
                  fnSub, fnSubu: modelReg[ins[15:11]] = rsV - rtV;
                  fnAnd: modelReg[ins[15:11]] = rsV & rtV;
                  fnOr:  modelReg[ins[15:11]] = rsV | rtV;
                  fnXor: modelReg[ins[15:11]] = rsV ^ rtV;
                  fnNor: modelReg[ins[15:11]] = ~(rsV | rtV);
                  fnSlt: modelReg[ins[15:11]] = {31'd0, $signed(rsV) < $signed(rtV)};
                  fnSltu: modelReg[ins[15:11]] = {31'd0, rsV < rtV};
                  fnJr: pcM = rsV;
                  default: ;
               endcase
            end
            opAddi, opAddiu: modelReg[ins[20:16]] = rsV + sImm;
            opSlti:  modelReg[ins[20:16]] = {31'd0, $signed(rsV) < $signed(sImm)};
            // sltiu is an unsigned compare with the sign-extended immediate
            opSltiu: modelReg[ins[20:16]] = {31'd0, rsV < sImm};
            opAndi:  modelReg[ins[20:16]] = rsV & zImm;
            opOri:   modelReg[ins[20:16]] = rsV | zImm;
            opXori:  modelReg[ins[20:16]] = rsV ^ zImm;
            opLui:   modelReg[ins[20:16]] = {ins[15:0], 16'd0};
            opLw: begin
               res = rsV + sImm;
               expRead.push_back(res);
               modelReg[ins[20:16]] = modelMem[res[13:2]];
            end
            opSw: begin
               res = rsV + sImm;
               modelMem[res[13:2]] = rtV;
               expAddr.push_back(res);
               expData.push_back(rtV);
            end
            opBeq: if (rsV == rtV) pcM = pcM + (sImm << 2);
            opBne: if (rsV != rtV) pcM = pcM + (sImm << 2);
            opJ:   pcM = {pcM[31:28], ins[25:0], 2'b00};
            opJal: begin
               modelReg[31] = pcM;
               pcM = {pcM[31:28], ins[25:0], 2'b00};
            end
            default: ;
         endcase
         modelReg[0] = 32'd0;
      end
   endtask

`endif

// ==== tbMips.sv ====
`timescale 1ns/1ps

module tbMips;
   import mipsPkg::*;

   localparam int   memWords = 4096;
   localparam int   timeoutCycles = 20000;
   localparam wordT dataBase = 32'h0000_3000;

   logic clk;
   logic reset;
   wordT memAddr;
   wordT memReadData;
   wordT memWriteData;
   logic memRead;
   logic memWrite;

   wordT mem [memWords];
   wordT genPc;
   wordT endAddr;
   logic [15:0] lfsr;
   logic prevRead;
   int   fetchCount;
   int   endHits;
   int   waitCycles;

   multiCycleMips #(.resetAddr(32'd0)) multiCycleMips_inst (
      .clk          (clk),
      .reset        (reset),
      .memAddr      (memAddr),
      .memReadData  (memReadData),
      .memWriteData (memWriteData),
      .memRead      (memRead),
      .memWrite     (memWrite)
   );

   bind multiCycleMips mipsChk chkInst (
      .clk      (clk),
      .reset    (reset),
      .memRead  (memRead),
      .memWrite (memWrite)
   );

   // combinational read port
   assign memReadData = mem[memAddr[13:2]];

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ============================================================
   // failure reporting and compare tasks
   // ============================================================
   task automatic reportFailure(string why);
      $display("%s at %0t", why, $time);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic checkAddr(wordT expected, wordT observed);
      if (expected !== observed) begin
         $display("FAIL time %0t memAddr expected %h observed %h", $time, expected, observed);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic checkData(wordT expected, wordT observed);
      if (expected !== observed) begin
         $display("FAIL time %0t memWriteData expected %h observed %h",
                  $time, expected, observed);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   `include "tbIsaModel.svh"

   // ============================================================
   // random numbers and instruction encoding
   // ============================================================
   function automatic logic [31:0] randBits(int n);
      logic [31:0] v;
      logic        fb;
      v = 32'd0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic wordT rType(functT fn, regAddrT rs, regAddrT rt, regAddrT rd);
      return {opRtype, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic wordT iType(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic wordT jType(opcodeT op, wordT target);
      return {op, target[27:2]};
   endfunction

   task automatic emit(wordT w);
      mem[genPc[13:2]] = w;
      genPc = genPc + 32'd4;
   endtask

   // store of a random low register into the scratch area
   task automatic emitMarkerStore();
      emit(iType(opSw, 5'd20, regAddrT'(randBits(4)), 16'h0080));
   endtask

   // ============================================================
   // program generator
   // ============================================================
   task automatic buildProgram();
      functT  rFns [10];
      opcodeT iOps [8];
      logic [8:0] off;
      regAddrT dst;
      rFns = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
      iOps = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
      for (int i = 0; i < memWords; i++) mem[i] = (i * 32'h9e37_79b1) ^ 32'h1234_5678;
      genPc = 32'd0;
      for (int r = 1; r < 16; r++) begin
         emit(iType(opLui, 5'd0, regAddrT'(r), 16'(randBits(16))));
         emit(iType(opOri, regAddrT'(r), regAddrT'(r), 16'(randBits(16))));
      end
      emit(iType(opOri, 5'd0, 5'd20, dataBase[15:0]));
      // random ALU mix, destinations include r0
      for (int i = 0; i < 48; i++) begin
         case (3'(randBits(3)))
            3'd0, 3'd1, 3'd2, 3'd3:
               emit(rType(rFns[randBits(4) % 10], regAddrT'(randBits(4)),
                          regAddrT'(randBits(4)), regAddrT'(randBits(4))));
            3'd7: begin
               if (randBits(1)) emit({6'h30 | 6'(randBits(2)), 26'(randBits(26))});
               else emit(rType(6'h00, regAddrT'(randBits(4)), regAddrT'(randBits(4)),
                               regAddrT'(randBits(4))));
            end
            default: emit(iType(iOps[randBits(3)], regAddrT'(randBits(4)),
                                regAddrT'(randBits(4)), 16'(randBits(16))));
         endcase
      end
      for (int i = 0; i < 6; i++) begin
         off = {7'(randBits(7)), 2'b00};
         dst = regAddrT'(randBits(4) % 15 + 1);
         emit(iType(opSw, 5'd20, regAddrT'(randBits(4)), {{7{off[8]}}, off}));
         emit(iType(opLw, 5'd20, dst, {{7{off[8]}}, off}));
         emit(iType(opSw, 5'd20, dst, 16'h0100 + 16'(i * 4)));
      end
      // forward branches over two stores each
      emit(iType(opBeq, 5'd1, 5'd1, 16'd2));
      emitMarkerStore();
      emitMarkerStore();
      emit(iType(opBne, 5'd1, 5'd1, 16'd2));
      emitMarkerStore();
      emitMarkerStore();
      for (int i = 0; i < 6; i++) begin
         emit(iType(randBits(1) ? opBne : opBeq, regAddrT'(randBits(4)),
                    regAddrT'(randBits(4)), 16'd2));
         emitMarkerStore();
         emitMarkerStore();
      end
      emit(jType(opJ, genPc + 32'd12));
      emitMarkerStore();
      emitMarkerStore();
      // jal over two stores, then jr through a computed address
      emit(jType(opJal, genPc + 32'd12));
      emitMarkerStore();
      emitMarkerStore();
      emit(iType(opAddiu, 5'd31, 5'd22, 16'd24));
      emit(rType(fnJr, 5'd22, 5'd0, 5'd0));
      emitMarkerStore();
      emitMarkerStore();
      // every register including r0
      for (int r = 0; r < 32; r++) begin
         emit(iType(opSw, 5'd20, regAddrT'(r), 16'h0200 + 16'(r * 4)));
      end
      endAddr = genPc;
      emit(jType(opJ, endAddr));
   endtask

   // ============================================================
   // store checking and fetch tracking
   // ============================================================
   always @(negedge clk) begin
      if (!reset) begin
         if (memWrite) begin
            if (expAddr.size() == 0) reportFailure("store seen with no store expected");
            checkAddr(expAddr.pop_front(), memAddr);
            checkData(expData.pop_front(), memWriteData);
            mem[memAddr[13:2]] = memWriteData;
         end
         if (memRead && !prevRead) begin
            // fetch and load reads in model order, first one at the reset address
            if (expRead.size() != 0) begin
               checkAddr(expRead.pop_front(), memAddr);
            end else begin
               checkAddr(endAddr, memAddr);
            end
            fetchCount++;
            if (memAddr == endAddr) endHits++;
         end
         prevRead = memRead;
      end
   end

   initial begin
      reset = 1'b1;
      lfsr = 16'd86;
      prevRead = 1'b0;
      fetchCount = 0;
      endHits = 0;
      buildProgram();
      runModel();
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;
      waitCycles = 0;
      while (fetchCount == 0) begin
         @(posedge clk);
         waitCycles++;
         if (waitCycles > 50) reportFailure("no fetch started after reset");
      end
      waitCycles = 0;
      while (endHits < 2) begin
         @(posedge clk);
         waitCycles++;
         if (waitCycles > timeoutCycles) reportFailure("program did not reach its end loop");
      end
      @(negedge clk);
      if (expAddr.size() != 0) begin
         $display("%0d expected stores never happened", expAddr.size());
         $display("Done: errors found");
         $fatal(1);
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

// ==== vlog.f ====
+incdir+.
mipsPkg.sv
mipsAlu.sv
regFile.sv
mipsControl.sv
mipsDatapath.sv
multiCycleMips.sv
mipsChk.sv
tbMips.sv
